/* vlog.f */
datapath_pkg.sv
alu.sv
register_file.sv
special_registers.sv
bus_mux.sv
datapath.sv
datapath_properties.sv
datapath_checker.sv
datapath_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run the datapath testbench.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f vlog.f \
    --top-module datapath_tb -Mdir obj_dir -o sim_datapath
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_datapath > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1

/* datapath_tb.sv */
`timescale 1ns/1ns
module datapath_tb;

    localparam int DATA_W   = 32;
    localparam int NUM_REGS = 16;

    logic clk;
    logic rst_n;
    datapath_pkg::load_ctrl_t load;
    datapath_pkg::out_ctrl_t  out;
    logic [NUM_REGS-1:0]      r_in;
    logic [NUM_REGS-1:0]      r_out;
    datapath_pkg::alu_op_e    alu_op;
    logic [DATA_W-1:0]        mdata_in;
    logic [DATA_W-1:0]        bus_data;
    logic [NUM_REGS-1:0][DATA_W-1:0] r_data;
    logic [DATA_W-1:0] pc_data, ir_data, mar_data, mdr_data, y_data, zhigh_data, zlow_data;
    logic              test_end;
    int                test_id;
    logic              exp_en;
    logic [3:0]        exp_idx;
    logic [DATA_W-1:0] exp_val;
    logic              done;
    int                errors;
    int                checks;
    int                timeouts;
    int                tests;
    datapath_pkg::alu_op_e ops [12];

    always #10 clk = ~clk;

    datapath #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) i_datapath (.*);

    datapath_checker #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) i_datapath_checker (.*);

    // Strobes drop at the next edge unless the following step sets them again.
    task automatic cycle_end();
        @(posedge clk);
        load  <= '0;
        out   <= '0;
        r_in  <= '0;
        r_out <= '0;
    endtask

    task automatic load_reg(int idx, logic [DATA_W-1:0] value);
        mdata_in    <= value;
        load.read   <= 1'b1;
        load.mdr_in <= 1'b1;
        cycle_end();
        out.mdr_out <= 1'b1;
        r_in[idx]   <= 1'b1;
        cycle_end();
    endtask

    task automatic finish_test(int id);
        int wait_cnt;
        wait_cnt = 0;
        tests++;
        test_id  <= id;
        test_end <= 1'b1;
        @(posedge clk);
        while (!done && wait_cnt < 50)
        begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!done)
        begin
            timeouts++;
            $display("timeout: checker never reported test %0d", id);
        end
        test_end <= 1'b0;
        @(posedge clk);
    endtask

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        load = '0;
        out = '0;
        r_in = '0;
        r_out = '0;
        alu_op = datapath_pkg::op_ld;
        mdata_in = '0;
        test_end = 1'b0;
        test_id = 0;
        exp_en = 1'b0;
        exp_idx = '0;
        exp_val = '0;
        timeouts = 0;
        tests = 0;
        void'($urandom(7552));
        ops = '{datapath_pkg::op_ld, datapath_pkg::op_add, datapath_pkg::op_sub,
                datapath_pkg::op_and, datapath_pkg::op_or, datapath_pkg::op_shr,
                datapath_pkg::op_shra, datapath_pkg::op_shl, datapath_pkg::op_rol,
                datapath_pkg::op_mul, datapath_pkg::op_neg, datapath_pkg::op_not};
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        finish_test(1); // Everything reads zero after reset.

        for (int k = 0; k < 8; k++)
            load_reg(int'($urandom % NUM_REGS), $urandom);
        finish_test(2);

        // Fetch sequence from a random start address.
        load_reg(0, $urandom);
        r_out[0] <= 1'b1;
        load.pc_in <= 1'b1;
        cycle_end();
        out.pc_out <= 1'b1;
        load.mar_in <= 1'b1;
        load.inc_pc <= 1'b1;
        load.z_in <= 1'b1;
        cycle_end();
        out.zlow_out <= 1'b1;
        load.pc_in <= 1'b1;
        load.read <= 1'b1;
        load.mdr_in <= 1'b1;
        mdata_in <= $urandom;
        cycle_end();
        out.mdr_out <= 1'b1;
        load.ir_in <= 1'b1;
        cycle_end();
        finish_test(3);

        // Rotate R6 right by R4 with the opcode taken from IR.
        load_reg(6, 32'h8000_FA92);
        load_reg(4, 32'h0000_000A);
        mdata_in <= {5'b01010, 27'h0};
        load.read <= 1'b1;
        load.mdr_in <= 1'b1;
        cycle_end();
        out.mdr_out <= 1'b1;
        load.ir_in <= 1'b1;
        cycle_end();
        r_out[6] <= 1'b1;
        load.y_in <= 1'b1;
        cycle_end();
        r_out[4] <= 1'b1;
        alu_op <= datapath_pkg::alu_op_e'(ir_data[31:27]);
        load.z_in <= 1'b1;
        cycle_end();
        out.zlow_out <= 1'b1;
        r_in[6] <= 1'b1;
        cycle_end();
        exp_en <= 1'b1;
        exp_idx <= 4'd6;
        exp_val <= 32'hA4A0_003E;
        @(posedge clk);
        exp_en <= 1'b0;
        finish_test(4);

        foreach (ops[i])
        begin
            load_reg(1, $urandom);
            load_reg(2, $urandom);
            r_out[1] <= 1'b1;
            load.y_in <= 1'b1;
            cycle_end();
            r_out[2] <= 1'b1;
            alu_op <= ops[i];
            load.z_in <= 1'b1;
            cycle_end();
            out.zlow_out <= 1'b1;
            r_in[3] <= 1'b1;
            cycle_end();
            out.zhigh_out <= 1'b1; // Upper half only carries the product.
            r_in[4] <= 1'b1;
            cycle_end();
        end
        finish_test(5);

        for (int k = 0; k < 4; k++)
            load_reg(k, $urandom);
        for (int k = 0; k < 4; k++)
        begin
            r_out[k] <= 1'b1;
            r_in[5] <= 1'b1;
            cycle_end();
        end
        finish_test(6);

        $display("tests %0d, checks %0d, errors %0d, timeouts %0d",
                 tests, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* datapath_checker.sv */
`timescale 1ns/1ns
module datapath_checker #(
    parameter int DATA_W   = 32,
    parameter int NUM_REGS = 16
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  datapath_pkg::load_ctrl_t         load,
    input  datapath_pkg::out_ctrl_t          out,
    input  logic [NUM_REGS-1:0]              r_in,
    input  logic [NUM_REGS-1:0]              r_out,
    input  datapath_pkg::alu_op_e            alu_op,
    input  logic [DATA_W-1:0]                mdata_in,
    input  logic [DATA_W-1:0]                bus_data,
    input  logic [NUM_REGS-1:0][DATA_W-1:0]  r_data,
    input  logic [DATA_W-1:0]                pc_data,
    input  logic [DATA_W-1:0]                ir_data,
    input  logic [DATA_W-1:0]                mar_data,
    input  logic [DATA_W-1:0]                mdr_data,
    input  logic [DATA_W-1:0]                y_data,
    input  logic [DATA_W-1:0]                zhigh_data,
    input  logic [DATA_W-1:0]                zlow_data,
    input  logic                             test_end,  // Pulse from the stimulus side.
    input  int                               test_id,
    input  logic                             exp_en,    // Extra fixed expectation.
    input  logic [3:0]                       exp_idx,
    input  logic [DATA_W-1:0]                exp_val,
    output logic                             done,
    output int                               errors,
    output int                               checks
);

    // Shadow copy of every register.
    logic [NUM_REGS-1:0][DATA_W-1:0] s_r;
    logic [DATA_W-1:0] s_pc, s_ir, s_mar, s_mdr, s_y, s_zh, s_zl;
    logic [DATA_W-1:0] s_bus;
    logic [2*DATA_W-1:0] s_alu;
    int last_errors;

    // Expected ALU output for one operation.
    function automatic logic [2*DATA_W-1:0] ref_alu(datapath_pkg::alu_op_e op,
                                                    logic [DATA_W-1:0] y,
                                                    logic [DATA_W-1:0] b,
                                                    logic inc);
        logic [DATA_W-1:0]   r;
        logic [2*DATA_W-1:0] p;
        int                  sh;
        sh = int'(b % DATA_W);
        r  = y;
        if (inc)
            return {{DATA_W{1'b0}}, b + {{(DATA_W-1){1'b0}}, 1'b1}};
        case (op)
            datapath_pkg::op_ld:  r = y;
            datapath_pkg::op_add: r = y + b;
            datapath_pkg::op_sub: r = y + ~b + {{(DATA_W-1){1'b0}}, 1'b1};
            datapath_pkg::op_and: r = y & b;
            datapath_pkg::op_or:  r = y | b;
            datapath_pkg::op_shr:
                for (int i = 0; i < sh; i++) r = {1'b0, r[DATA_W-1:1]};
            datapath_pkg::op_shra:
                for (int i = 0; i < sh; i++) r = {r[DATA_W-1], r[DATA_W-1:1]};
            datapath_pkg::op_shl:
                for (int i = 0; i < sh; i++) r = {r[DATA_W-2:0], 1'b0};
            datapath_pkg::op_ror:
                for (int i = 0; i < sh; i++) r = {r[0], r[DATA_W-1:1]};
            datapath_pkg::op_rol:
                for (int i = 0; i < sh; i++) r = {r[DATA_W-2:0], r[DATA_W-1]};
            datapath_pkg::op_mul:
            begin
                // Operands sign-extended to double width give the signed product.
                p = {{DATA_W{y[DATA_W-1]}}, y} * {{DATA_W{b[DATA_W-1]}}, b};
                return p;
            end
            datapath_pkg::op_neg: r = ~b + {{(DATA_W-1){1'b0}}, 1'b1};
            datapath_pkg::op_not: r = ~b;
            default:              r = '0;
        endcase
        return {{DATA_W{1'b0}}, r};
    endfunction

    task automatic compare(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    always_comb
    begin
        s_bus = '0;
        for (int i = 0; i < NUM_REGS; i++)
            if (r_out[i]) s_bus = s_r[i];
        if (out.pc_out)    s_bus = s_pc;
        if (out.mdr_out)   s_bus = s_mdr;
        if (out.zhigh_out) s_bus = s_zh;
        if (out.zlow_out)  s_bus = s_zl;
        s_alu = ref_alu(alu_op, s_y, s_bus, load.inc_pc);
    end

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            s_r <= '0;
            {s_pc, s_ir, s_mar, s_mdr, s_y, s_zh, s_zl} <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_REGS; i++)
                if (r_in[i]) s_r[i] <= s_bus;
            if (load.pc_in)  s_pc  <= s_bus;
            if (load.ir_in)  s_ir  <= s_bus;
            if (load.mar_in) s_mar <= s_bus;
            if (load.mdr_in) s_mdr <= load.read ? mdata_in : s_bus;
            if (load.y_in)   s_y   <= s_bus;
            if (load.z_in)   {s_zh, s_zl} <= s_alu;
        end
    end

    initial
    begin
        errors      = 0;
        checks      = 0;
        last_errors = 0;
        done        = 1'b0;
    end

    // Outputs have settled by the falling edge.
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            compare("bus_data", s_bus, bus_data);
            for (int i = 0; i < NUM_REGS; i++)
                compare($sformatf("r_data[%0d]", i), s_r[i], r_data[i]);
            compare("pc_data", s_pc, pc_data);
            compare("ir_data", s_ir, ir_data);
            compare("mar_data", s_mar, mar_data);
            compare("mdr_data", s_mdr, mdr_data);
            compare("y_data", s_y, y_data);
            compare("zhigh_data", s_zh, zhigh_data);
            compare("zlow_data", s_zl, zlow_data);
            if (exp_en)
                compare($sformatf("r_data[%0d]", exp_idx), exp_val, r_data[exp_idx]);
        end
        if (test_end && !done)
        begin
            if (errors == last_errors)
                $display("test %0d: ok", test_id);
            else
                $display("test %0d: %0d errors", test_id, errors - last_errors);
            last_errors = errors;
        end
        done <= test_end;
    end

endmodule

/* datapath_properties.sv */
`timescale 1ns/1ns
module datapath_properties #(
    parameter int DATA_W   = 32,
    parameter int NUM_REGS = 16
) (
    input logic                             clk,
    input logic                             rst_n,
    input datapath_pkg::load_ctrl_t         load,
    input datapath_pkg::out_ctrl_t          out,
    input logic [NUM_REGS-1:0]              r_in,
    input logic [NUM_REGS-1:0]              r_out,
    input logic [DATA_W-1:0]                bus_data,
    input logic [NUM_REGS-1:0][DATA_W-1:0]  r_data,
    input logic [DATA_W-1:0]                pc_data,
    input logic [DATA_W-1:0]                y_data
);

    one_source: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({r_out, out})) else $error("more than one bus source");

    idle_bus_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ({r_out, out} == '0) |-> (bus_data == '0)) else $error("idle bus not zero");

    // A cleared register stays cleared until its strobe.
    regs_hold_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (r_data == '0 && r_in == '0) |=> (r_data == '0)) else $error("register left zero");
    pc_hold_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (pc_data == '0 && !load.pc_in) |=> (pc_data == '0)) else $error("pc left zero");
    y_hold_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (y_data == '0 && !load.y_in) |=> (y_data == '0)) else $error("y left zero");

endmodule

bind datapath datapath_properties #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS))
    i_datapath_properties (.*);

/* datapath.sv */
`timescale 1ns/1ns
module datapath #(
    parameter int DATA_W   = datapath_pkg::DATA_W_DEFAULT,
    parameter int NUM_REGS = datapath_pkg::NUM_REGS_DEFAULT
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  datapath_pkg::load_ctrl_t         load,
    input  datapath_pkg::out_ctrl_t          out,
    input  logic [NUM_REGS-1:0]              r_in,
    input  logic [NUM_REGS-1:0]              r_out,
    input  datapath_pkg::alu_op_e            alu_op,
    input  logic [DATA_W-1:0]                mdata_in,
    output logic [DATA_W-1:0]                bus_data,
    output logic [NUM_REGS-1:0][DATA_W-1:0]  r_data,
    output logic [DATA_W-1:0]                pc_data,
    output logic [DATA_W-1:0]                ir_data,
    output logic [DATA_W-1:0]                mar_data,
    output logic [DATA_W-1:0]                mdr_data,
    output logic [DATA_W-1:0]                y_data,
    output logic [DATA_W-1:0]                zhigh_data,
    output logic [DATA_W-1:0]                zlow_data
);

    logic [2*DATA_W-1:0] alu_result; // Full width result into Z.

    alu #(.DATA_W(DATA_W)) i_alu (
        .y      (y_data),
        .b      (bus_data),
        .op     (alu_op),
        .inc_pc (load.inc_pc),
        .result (alu_result)
    );

    register_file #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) i_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .r_in     (r_in),
        .bus_data (bus_data),
        .r_data   (r_data)
    );

    special_registers #(.DATA_W(DATA_W)) i_special_registers (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .bus_data   (bus_data),
        .mdata_in   (mdata_in),
        .alu_result (alu_result),
        .pc_data    (pc_data),
        .ir_data    (ir_data),
        .mar_data   (mar_data),
        .mdr_data   (mdr_data),
        .y_data     (y_data),
        .zhigh_data (zhigh_data),
        .zlow_data  (zlow_data)
    );

    // Single shared bus.
    bus_mux #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) i_bus_mux (
        .r_out      (r_out),
        .out        (out),
        .r_data     (r_data),
        .pc_data    (pc_data),
        .mdr_data   (mdr_data),
        .zhigh_data (zhigh_data),
        .zlow_data  (zlow_data),
        .bus_data   (bus_data)
    );

endmodule

/* bus_mux.sv */
`timescale 1ns/1ns
module bus_mux #(
    parameter int DATA_W   = 32,
    parameter int NUM_REGS = 16
) (
    input  logic [NUM_REGS-1:0]              r_out,
    input  datapath_pkg::out_ctrl_t          out,
    input  logic [NUM_REGS-1:0][DATA_W-1:0]  r_data,
    input  logic [DATA_W-1:0]                pc_data,
    input  logic [DATA_W-1:0]                mdr_data,
    input  logic [DATA_W-1:0]                zhigh_data,
    input  logic [DATA_W-1:0]                zlow_data,
    output logic [DATA_W-1:0]                bus_data
);

    localparam int NUM_SRC = NUM_REGS + 4;
    localparam int IDX_W   = $clog2(NUM_SRC);

    logic [NUM_SRC-1:0]             sel; // All out strobes, general registers first.
    logic [NUM_SRC-1:0][DATA_W-1:0] src;
    logic [IDX_W-1:0]               idx;
    logic                           hit;

    assign sel = {out.zlow_out, out.zhigh_out, out.mdr_out, out.pc_out, r_out};
    assign src = {zlow_data, zhigh_data, mdr_data, pc_data, r_data};

    // The downward scan leaves the lowest set index.
    always_comb
    begin
        idx = '0;
        hit = 1'b0;
        for (int i = NUM_SRC - 1; i >= 0; i--)
        begin
            if (sel[i])
            begin
                idx = IDX_W'(i);
                hit = 1'b1;
            end
        end
    end

    assign bus_data = hit ? src[idx] : '0; // Idle bus reads zero.

endmodule

/* special_registers.sv */
`timescale 1ns/1ns
module special_registers #(
    parameter int DATA_W = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  datapath_pkg::load_ctrl_t load,
    input  logic [DATA_W-1:0]        bus_data,
    input  logic [DATA_W-1:0]        mdata_in,
    input  logic [2*DATA_W-1:0]      alu_result,
    output logic [DATA_W-1:0]        pc_data,
    output logic [DATA_W-1:0]        ir_data,
    output logic [DATA_W-1:0]        mar_data,
    output logic [DATA_W-1:0]        mdr_data,
    output logic [DATA_W-1:0]        y_data,
    output logic [DATA_W-1:0]        zhigh_data,
    output logic [DATA_W-1:0]        zlow_data
);

    logic [DATA_W-1:0] mdr_d; // MDR input after the read select.

    assign mdr_d = load.read ? mdata_in : bus_data;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc_data    <= '0;
            ir_data    <= '0;
            mar_data   <= '0;
            mdr_data   <= '0;
            y_data     <= '0;
            zhigh_data <= '0;
            zlow_data  <= '0;
        end
        else
        begin
            if (load.pc_in)  pc_data  <= bus_data;
            if (load.ir_in)  ir_data  <= bus_data;
            if (load.mar_in) mar_data <= bus_data; // Address toward memory.
            if (load.mdr_in) mdr_data <= mdr_d;
            if (load.y_in)   y_data   <= bus_data; // First ALU operand.
            if (load.z_in)
            begin
                zhigh_data <= alu_result[2*DATA_W-1:DATA_W];
                zlow_data  <= alu_result[DATA_W-1:0];
            end
        end
    end

endmodule

/* register_file.sv */
`timescale 1ns/1ns
module register_file #(
    parameter int DATA_W   = 32,
    parameter int NUM_REGS = 16
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_REGS-1:0]              r_in,
    input  logic [DATA_W-1:0]                bus_data,
    output logic [NUM_REGS-1:0][DATA_W-1:0]  r_data
);

    // One storage array so the contents leave as a single port.
    logic [NUM_REGS-1:0][DATA_W-1:0] regs;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            regs <= '0;
        end
        else
        begin
            // Each register has its own in strobe.
            for (int i = 0; i < NUM_REGS; i++)
            begin
                if (r_in[i])
                begin
                    regs[i] <= bus_data;
                end
            end
        end
    end

    assign r_data = regs;

endmodule

/* alu.sv */
`timescale 1ns/1ns
module alu #(
    parameter int DATA_W = 32
) (
    input  logic [DATA_W-1:0]     y,
    input  logic [DATA_W-1:0]     b,
    input  datapath_pkg::alu_op_e op,
    input  logic                  inc_pc,
    output logic [2*DATA_W-1:0]   result
);

    localparam int SH_W = $clog2(DATA_W);

    logic [SH_W-1:0]            sh;      // Shift amount from the low bits of the bus.
    logic [DATA_W-1:0]          low;     // Single word result.
    logic                       use_mul; // Product fills both halves.
    logic signed [2*DATA_W-1:0] product;

    assign sh = b[SH_W-1:0];

    // Both operands are sign-extended to the full width.
    assign product = $signed(y) * $signed(b);

    always_comb
    begin
        low     = '0;
        use_mul = 1'b0;
        if (inc_pc)
        begin
            low = b + 1'b1; // PC increment overrides the opcode.
        end
        else
        begin
            case (op)
                datapath_pkg::op_ld:
                begin
                    low = y;
                end
                datapath_pkg::op_add:
                begin
                    low = y + b;
                end
                datapath_pkg::op_sub:
                begin
                    low = y - b;
                end
                datapath_pkg::op_and:
                begin
                    low = y & b;
                end
                datapath_pkg::op_or:
                begin
                    low = y | b;
                end
                datapath_pkg::op_shr:
                begin
                    low = y >> sh;
                end
                datapath_pkg::op_shra:
                begin
                    low = $signed(y) >>> sh; // Sign bit fills from the left.
                end
                datapath_pkg::op_shl:
                begin
                    low = y << sh;
                end
                datapath_pkg::op_ror:
                begin
                    low = (y >> sh) | (y << (DATA_W - sh));
                end
                datapath_pkg::op_rol:
                begin
                    low = (y << sh) | (y >> (DATA_W - sh));
                end
                datapath_pkg::op_mul:
                begin
                    use_mul = 1'b1;
                end
                datapath_pkg::op_neg:
                begin
                    low = -b;
                end
                datapath_pkg::op_not:
                begin
                    low = ~b;
                end
                default:
                begin
                    low = '0; // Undefined opcodes give zero.
                end
            endcase
        end
    end

    // Only the product reaches the high half.
    assign result = use_mul ? product : {{DATA_W{1'b0}}, low};

endmodule

/* datapath_pkg.sv */
package datapath_pkg;

    parameter int DATA_W_DEFAULT   = 32; // Word width of the datapath.
    parameter int NUM_REGS_DEFAULT = 16; // General purpose register count.

    // ALU opcodes, encoded as the top five bits of the instruction word.
    typedef enum logic [4:0] {
        op_ld   = 5'd0,  // No ALU action, Y passes through.
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_and  = 5'd5,
        op_or   = 5'd6,
        op_shr  = 5'd7,
        op_shra = 5'd8,
        op_shl  = 5'd9,
        op_ror  = 5'd10,
        op_rol  = 5'd11,
        op_mul  = 5'd15,
        op_neg  = 5'd17,
        op_not  = 5'd18
    } alu_op_e;

    // Load strobes for the special registers.
    typedef struct packed {
        logic pc_in;
        logic ir_in;
        logic mar_in;
        logic mdr_in;
        logic read;   // MDR takes memory data instead of the bus.
        logic y_in;
        logic z_in;
        logic inc_pc; // ALU produces bus plus one.
    } load_ctrl_t;

    // Bus source strobes for the special registers.
    typedef struct packed {
        logic pc_out;
        logic mdr_out;
        logic zhigh_out;
        logic zlow_out;
    } out_ctrl_t;

endpackage
